//--- build.f
hw/dsp_pkg.sv
hw/detect_pkg.sv
hw/bram_infer.sv
hw/sample_rectifier.sv
hw/moving_average_unsign.sv
hw/level_detector.sv
hw/envelope_detector_top.sv
verif/tb_envelope_detector.sv

//--- Makefile
SRCS := $(shell cat build.f)

all: run

obj_near/Vtb_envelope_detector: build.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_envelope_detector \
		-GROUND_NEAREST=1 --Mdir obj_near -f build.f

obj_trunc/Vtb_envelope_detector: build.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_envelope_detector \
		-GROUND_NEAREST=0 --Mdir obj_trunc -f build.f

run: obj_near/Vtb_envelope_detector obj_trunc/Vtb_envelope_detector
	./obj_near/Vtb_envelope_detector > sim_near.log
	./obj_trunc/Vtb_envelope_detector > sim_trunc.log
	cat sim_near.log sim_trunc.log
	@if grep -q "=== FAIL ===" sim_near.log sim_trunc.log; then exit 1; fi

clean:
	rm -rf obj_near obj_trunc sim_near.log sim_trunc.log

.PHONY: all run clean

//--- verif/tb_envelope_detector.sv
`timescale 1ns/1ps

module tb_envelope_detector import dsp_pkg::*, detect_pkg::*; #(
    parameter int ROUND_NEAREST = 1  // Zero selects truncation.
);

    localparam int SAMPLE_WIDTH = 16;
    localparam int WINDOW_LEN   = 16;
    localparam int SMAX         = 2**(SAMPLE_WIDTH-1) - 1;
    localparam int SMIN         = -(2**(SAMPLE_WIDTH-1));
    localparam int UMAX         = 2**SAMPLE_WIDTH - 1;
    localparam int PIPE         = 5;  // Sample in to avg_valid.

    logic                           clk;
    logic                           rst;
    logic signed [SAMPLE_WIDTH-1:0] sample;
    logic                           sample_valid;
    logic signed [SAMPLE_WIDTH-1:0] offset;
    logic        [SAMPLE_WIDTH-1:0] thresh_on;
    logic        [SAMPLE_WIDTH-1:0] thresh_off;
    logic        [SAMPLE_WIDTH-1:0] avg;
    logic                           avg_valid;
    logic                           detect;
    logic                           rise;
    logic                           fall;

    int         hist[$];           // Last WINDOW_LEN magnitudes.
    logic       exp_vld [PIPE];
    int         exp_avg [PIPE];
    det_state_e model_state;
    logic       model_rise;
    logic       model_fall;
    int         sent_cnt   = 0;
    int         recv_cnt   = 0;
    int         last_avg   = 0;
    int         rise_total = 0;
    int         fall_total = 0;

    int err_valid  = 0;
    int err_avg    = 0;
    int err_detect = 0;
    int err_edge   = 0;
    int err_check  = 0;
    int timeouts   = 0;

    envelope_detector_top #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .WINDOW_LEN   (WINDOW_LEN),
        .APPROX       ((ROUND_NEAREST != 0) ? approx_nearest : approx_truncate)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .offset       (offset),
        .thresh_on    (thresh_on),
        .thresh_off   (thresh_off),
        .avg          (avg),
        .avg_valid    (avg_valid),
        .detect       (detect),
        .rise         (rise),
        .fall         (fall)
    );

    always #10 clk = ~clk;

    // Offset removal, clamp to the signed range, then magnitude.
    function automatic int mag_of(input int value, input int off);
        int diff;
        diff = value - off;
        if (diff > SMAX) begin
            diff = SMAX;
        end else if (diff < SMIN) begin
            diff = SMIN;
        end
        return (diff < 0) ? -diff : diff;
    endfunction

    function automatic int avg_of(input int sum);
        int q;
        if (ROUND_NEAREST != 0) begin
            q = (sum + WINDOW_LEN / 2) / WINDOW_LEN;  // Half up.
        end else begin
            q = sum / WINDOW_LEN;
        end
        return (q > UMAX) ? UMAX : q;
    endfunction

    always @(posedge clk) begin : ref_model
        int m;
        int sum;
        int k;
        if (rst) begin
            hist.delete();
            for (k = 0; k < PIPE; k++) begin
                exp_vld[k] <= 1'b0;
            end
            model_state <= det_idle;
            model_rise  <= 1'b0;
            model_fall  <= 1'b0;
            sent_cnt    <= recv_cnt;  // In-flight samples are lost.
        end else begin
            if (sample_valid) begin
                m = mag_of(int'(sample), int'(offset));
                hist.push_back(m);
                if (hist.size() > WINDOW_LEN) begin
                    void'(hist.pop_front());
                end
                sum = 0;
                for (k = 0; k < hist.size(); k++) begin
                    sum += hist[k];  // Missing entries count as zero.
                end
                exp_avg[0] <= avg_of(sum);
                sent_cnt   <= sent_cnt + 1;
            end
            exp_vld[0] <= sample_valid;
            for (k = 1; k < PIPE; k++) begin
                exp_vld[k] <= exp_vld[k-1];
                exp_avg[k] <= exp_avg[k-1];
            end
            model_rise <= 1'b0;
            model_fall <= 1'b0;
            if (exp_vld[PIPE-1]) begin
                if (model_state == det_idle && exp_avg[PIPE-1] >= int'(thresh_on)) begin
                    model_state <= det_active;
                    model_rise  <= 1'b1;
                end else if (model_state == det_active &&
                             exp_avg[PIPE-1] < int'(thresh_off)) begin
                    model_state <= det_idle;
                    model_fall  <= 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && avg_valid) begin
            recv_cnt <= recv_cnt + 1;
            last_avg <= int'(avg);
        end
        if (!rst && rise) begin
            rise_total <= rise_total + 1;
        end
        if (!rst && fall) begin
            fall_total <= fall_total + 1;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (rst)
        avg_valid == exp_vld[PIPE-1])
        else begin
            err_valid++;
            $display("ERR avg_valid: got %h expected %h",
                     $sampled(avg_valid), $sampled(exp_vld[PIPE-1]));
        end

    a_avg: assert property (@(posedge clk) disable iff (rst)
        avg_valid |-> int'(avg) == exp_avg[PIPE-1])
        else begin
            err_avg++;
            $display("ERR avg: got %h expected %h",
                     $sampled(avg), $sampled(exp_avg[PIPE-1]));
        end

    a_detect: assert property (@(posedge clk) disable iff (rst)
        detect == (model_state == det_active))
        else begin
            err_detect++;
            $display("ERR detect: got %h expected %h",
                     $sampled(detect), $sampled(model_state) == det_active);
        end

    a_state: assert property (@(posedge clk) disable iff (rst)
        dut0.u_det.state == model_state)
        else begin
            err_detect++;
            $display("ERR state: got %h expected %h",
                     $sampled(dut0.u_det.state), $sampled(model_state));
        end

    a_rise: assert property (@(posedge clk) disable iff (rst) rise == model_rise)
        else begin
            err_edge++;
            $display("ERR rise: got %h expected %h", $sampled(rise), $sampled(model_rise));
        end

    a_fall: assert property (@(posedge clk) disable iff (rst) fall == model_fall)
        else begin
            err_edge++;
            $display("ERR fall: got %h expected %h", $sampled(fall), $sampled(model_fall));
        end

    task automatic push_sample(input int value, input int off, input int gap);
        int g;
        @(posedge clk);
        sample       <= SAMPLE_WIDTH'(value);
        offset       <= SAMPLE_WIDTH'(off);
        sample_valid <= 1'b1;
        for (g = 0; g < gap; g++) begin
            @(posedge clk);
            sample_valid <= 1'b0;
        end
    endtask

    task automatic stream_const(input int value, input int off, input int count);
        int n;
        for (n = 0; n < count; n++) begin
            push_sample(value, off, 0);
        end
    endtask

    // Waits until every accepted sample has produced its avg_valid.
    task automatic drain_pipeline();
        int cycles;
        @(posedge clk);
        sample_valid <= 1'b0;
        @(posedge clk);
        cycles = 0;
        while (recv_cnt != sent_cnt && cycles < 4 * PIPE) begin
            @(posedge clk);
            cycles++;
        end
        if (recv_cnt != sent_cnt) begin
            timeouts++;
            $display("Timeout: avg_valid never came for %0d samples", sent_cnt - recv_cnt);
        end
        @(posedge clk);  // Lets detect and the edge counters settle.
    endtask

    task automatic compare_avg(input int want);
        assert (last_avg == want) else begin
            err_check++;
            $display("ERR avg: got %h expected %h", last_avg, want);
        end
    endtask

    task automatic const_case(input int value, input int off, input int want);
        stream_const(value, off, WINDOW_LEN + 8);
        drain_pipeline();
        compare_avg(want);
    endtask

    task automatic expect_level(input logic want);
        assert (detect == want) else begin
            err_check++;
            $display("ERR detect: got %h expected %h", detect, want);
        end
    endtask

    task automatic verify_edges(input int rise_from, input int fall_from,
                                input int n_rise, input int n_fall);
        assert (rise_total - rise_from == n_rise) else begin
            err_check++;
            $display("ERR rise: got %h pulses expected %h", rise_total - rise_from, n_rise);
        end
        assert (fall_total - fall_from == n_fall) else begin
            err_check++;
            $display("ERR fall: got %h pulses expected %h", fall_total - fall_from, n_fall);
        end
    endtask

    initial begin : stimulus
        int i;
        int r0;
        int f0;
        int total;
        void'($urandom(32'h94f5));
        clk          = 1'b0;
        rst          = 1'b1;
        sample       = '0;
        sample_valid = 1'b0;
        offset       = '0;
        thresh_on    = SAMPLE_WIDTH'(20000);
        thresh_off   = SAMPLE_WIDTH'(10000);
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        const_case(8000, 0, 8000);       // Step ramps over one window.
        const_case(32767, -100, 32767);  // Clamped high.
        const_case(-32768, 100, 32768);
        const_case(-32768, -5, 32763);
        const_case(32000, -1000, 32767);
        const_case(-20000, 12345, 32345);
        const_case(100, 300, 200);

        for (i = 0; i < 200; i++) begin
            push_sample(int'($urandom_range(0, 65535)) - 32768,
                        int'($urandom_range(0, 4000)) - 2000,
                        (i < 100) ? 0 : int'($urandom_range(0, 3)));
        end
        drain_pipeline();

        // Ramp up and down across both thresholds.
        const_case(0, 0, 0);
        r0 = rise_total;
        f0 = fall_total;
        for (i = 0; i <= 30; i++) begin
            push_sample(i * 1000, 0, 0);
        end
        stream_const(30000, 0, WINDOW_LEN);
        stream_const(15000, 0, 2 * WINDOW_LEN);
        drain_pipeline();
        expect_level(1'b1);  // Between thresholds.
        stream_const(0, 0, 2 * WINDOW_LEN);
        drain_pipeline();
        expect_level(1'b0);
        verify_edges(r0, f0, 1, 1);

        // Reset while samples are in flight.
        thresh_on  <= SAMPLE_WIDTH'(1000);
        thresh_off <= SAMPLE_WIDTH'(500);
        stream_const(20000, 0, 12);
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst          <= 1'b0;
        sample_valid <= 1'b0;
        @(posedge clk);
        expect_level(1'b0);
        r0 = rise_total;
        f0 = fall_total;
        const_case(4000, -1000, 5000);
        verify_edges(r0, f0, 1, 0);

        total = err_valid + err_avg + err_detect + err_edge + err_check + timeouts;
        $display("errors: valid=%0d avg=%0d detect=%0d edges=%0d checks=%0d timeouts=%0d",
                 err_valid, err_avg, err_detect, err_edge, err_check, timeouts);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #1000000;
        $display("Watchdog: simulation ran past its time limit");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- hw/envelope_detector_top.sv
`timescale 1ns/1ps

// Envelope detector: rectifier, moving average, hysteresis detector.
// An input sample gives avg_valid after 5 cycles and a detect update after 6.
module envelope_detector_top import dsp_pkg::*; #(
    parameter int      SAMPLE_WIDTH = 16,
    parameter int      WINDOW_LEN   = 16,  // Power of two.
    parameter approx_e APPROX       = approx_nearest
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic signed [SAMPLE_WIDTH-1:0] sample,
    input  logic                           sample_valid,
    input  logic signed [SAMPLE_WIDTH-1:0] offset,
    input  logic        [SAMPLE_WIDTH-1:0] thresh_on,
    input  logic        [SAMPLE_WIDTH-1:0] thresh_off,
    output logic        [SAMPLE_WIDTH-1:0] avg,
    output logic                           avg_valid,
    output logic                           detect,
    output logic                           rise,
    output logic                           fall
);

    logic [SAMPLE_WIDTH-1:0] mag;
    logic                    mag_valid;

    sample_rectifier #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) u_rect (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .offset       (offset),
        .mag          (mag),
        .mag_valid    (mag_valid)
    );

    moving_average_unsign #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .WINDOW_LEN   (WINDOW_LEN),
        .APPROX       (APPROX)
    ) u_avg (
        .clk        (clk),
        .rst        (rst),
        .din        (mag),
        .din_valid  (mag_valid),
        .dout       (avg),
        .dout_valid (avg_valid)
    );

    // State is reached hierarchically by the testbench.
    level_detector #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) u_det (
        .clk        (clk),
        .rst        (rst),
        .avg        (avg),
        .avg_valid  (avg_valid),
        .thresh_on  (thresh_on),
        .thresh_off (thresh_off),
        .detect     (detect),
        .rise       (rise),
        .fall       (fall),
        .state      ()
    );

endmodule

//--- hw/level_detector.sv
`timescale 1ns/1ps

// Threshold detector with hysteresis on the averaged envelope.
// State, detect and the edge pulses change one cycle after avg_valid.
module level_detector import detect_pkg::*; #(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [SAMPLE_WIDTH-1:0] avg,
    input  logic                    avg_valid,
    input  logic [SAMPLE_WIDTH-1:0] thresh_on,
    input  logic [SAMPLE_WIDTH-1:0] thresh_off,
    output logic                    detect,
    output logic                    rise,
    output logic                    fall,
    output det_state_e              state
);

    det_state_e state_r;
    det_state_e state_nxt;
    logic       go_on;    // Entry condition.
    logic       go_off;   // Exit condition.

    assign go_on  = avg_valid && (avg >= thresh_on);
    assign go_off = avg_valid && (avg < thresh_off);

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            det_idle: begin
                if (go_on) begin
                    state_nxt = det_active;
                end
            end
            det_active: begin
                if (go_off) begin
                    state_nxt = det_idle;
                end
            end
            default: begin
                state_nxt = det_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= det_idle;
            rise    <= 1'b0;
            fall    <= 1'b0;
        end else begin
            state_r <= state_nxt;
            rise    <= (state_r == det_idle) && (state_nxt == det_active);
            fall    <= (state_r == det_active) && (state_nxt == det_idle);
        end
    end

    // Level output follows the state register directly.
    assign detect = (state_r == det_active);
    assign state  = state_r;

endmodule

//--- hw/moving_average_unsign.sv
`timescale 1ns/1ps

// Moving average of an unsigned stream over a power-of-two window.
// A RAM delay line feeds a comb stage, and an integrator follows.
// Output valid comes 4 cycles after the input strobe.
module moving_average_unsign import dsp_pkg::*; #(
    parameter int      SAMPLE_WIDTH = 16,
    parameter int      WINDOW_LEN   = 16,
    parameter approx_e APPROX       = approx_nearest
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [SAMPLE_WIDTH-1:0] din,
    input  logic                    din_valid,
    output logic [SAMPLE_WIDTH-1:0] dout,
    output logic                    dout_valid
);

    localparam int LOG_W = $clog2(WINDOW_LEN);
    localparam int SUM_W = SAMPLE_WIDTH + LOG_W;

    logic [LOG_W-1:0]        w_addr;
    logic [LOG_W-1:0]        w_addr_d1;   // Write is one cycle behind the read.
    logic [LOG_W:0]          fill_cnt;    // Saturates at WINDOW_LEN.
    logic                    filled;

    logic                    valid_s1, valid_s2, valid_s3;
    logic                    full_s1, full_s2;
    logic [SAMPLE_WIDTH-1:0] din_s1, din_s2;
    logic [SAMPLE_WIDTH-1:0] old_val;     // Sample leaving the window.
    logic [SAMPLE_WIDTH-1:0] old_sel;

    logic signed [SAMPLE_WIDTH:0] comb;
    logic [SUM_W-1:0]        integ;
    logic [SAMPLE_WIDTH-1:0] quot;
    logic                    dout_valid_r;

    assign filled = fill_cnt[LOG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            w_addr   <= '0;
            fill_cnt <= '0;
        end else if (din_valid) begin
            w_addr <= w_addr + 1'b1;
            if (!filled) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // Slot w_addr still holds the sample from WINDOW_LEN inputs ago.
    bram_infer #(
        .N_ADDR     (WINDOW_LEN),
        .DATA_WIDTH (SAMPLE_WIDTH)
    ) u_dly (
        .clk  (clk),
        .wen  (valid_s1),
        .ren  (din_valid),
        .wadd (w_addr_d1),
        .radd (w_addr),
        .win  (din_s1),
        .wout (old_val)
    );

    // Stages 1 and 2 follow the RAM read latency.
    always_ff @(posedge clk) begin
        w_addr_d1 <= w_addr;
        din_s1    <= din;
        din_s2    <= din_s1;
        full_s1   <= filled;
        full_s2   <= full_s1;
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
        end else begin
            valid_s1 <= din_valid;
            valid_s2 <= valid_s1;
            valid_s3 <= valid_s2;
        end
    end

    assign old_sel = full_s2 ? old_val : '0;  // Stale RAM ignored while filling.

    always_ff @(posedge clk) begin
        if (valid_s2) begin
            comb <= $signed({1'b0, din_s2}) - $signed({1'b0, old_sel});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            integ        <= '0;
            dout_valid_r <= 1'b0;
        end else begin
            dout_valid_r <= valid_s3;
            if (valid_s3) begin
                integ <= integ + SUM_W'(comb);  // Sign extended difference.
            end
        end
    end

    assign quot = integ[SUM_W-1:LOG_W];

    always_comb begin
        if (APPROX == approx_nearest && integ[LOG_W-1] && quot != '1) begin
            dout = quot + 1'b1;  // Half up, held at full scale.
        end else begin
            dout = quot;
        end
    end

    assign dout_valid = dout_valid_r;

endmodule

//--- hw/sample_rectifier.sv
`timescale 1ns/1ps

// Removes a DC offset from a signed sample and returns its magnitude.
module sample_rectifier #(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic signed [SAMPLE_WIDTH-1:0] sample,
    input  logic                           sample_valid,
    input  logic signed [SAMPLE_WIDTH-1:0] offset,
    output logic        [SAMPLE_WIDTH-1:0] mag,
    output logic                           mag_valid
);

    localparam logic signed [SAMPLE_WIDTH-1:0] SAT_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    localparam logic signed [SAMPLE_WIDTH-1:0] SAT_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

    logic signed [SAMPLE_WIDTH:0]   diff;     // One guard bit.
    logic signed [SAMPLE_WIDTH-1:0] sat;
    logic        [SAMPLE_WIDTH-1:0] abs_val;

    always_comb begin
        diff = sample - offset;
        if (diff[SAMPLE_WIDTH] != diff[SAMPLE_WIDTH-1]) begin
            sat = diff[SAMPLE_WIDTH] ? SAT_MIN : SAT_MAX;  // Clamp on overflow.
        end else begin
            sat = diff[SAMPLE_WIDTH-1:0];
        end
        // Most negative value maps to 2**(SAMPLE_WIDTH-1), still in range.
        abs_val = sat[SAMPLE_WIDTH-1] ? (~sat + 1'b1) : sat;
    end

    always_ff @(posedge clk) begin
        mag <= abs_val;
        if (rst) begin
            mag_valid <= 1'b0;
        end else begin
            mag_valid <= sample_valid;
        end
    end

endmodule

//--- hw/bram_infer.sv
`timescale 1ns/1ps

// Simple dual-port RAM, one write port and one read port.
// The read address and the read data are both registered.
// Data appears two cycles after radd is presented with ren high.
module bram_infer #(
    parameter int N_ADDR     = 16,
    parameter int DATA_WIDTH = 16
) (
    input  logic                      clk,
    input  logic                      wen,
    input  logic                      ren,
    input  logic [$clog2(N_ADDR)-1:0] wadd,
    input  logic [$clog2(N_ADDR)-1:0] radd,
    input  logic [DATA_WIDTH-1:0]     win,
    output logic [DATA_WIDTH-1:0]     wout
);

    localparam int ADDR_W = $clog2(N_ADDR);

    logic [DATA_WIDTH-1:0] mem [N_ADDR];
    logic [ADDR_W-1:0]     radd_r;   // Read address register.
    logic [DATA_WIDTH-1:0] rdata_r;  // Output register.

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[wadd] <= win;
        end
        if (ren) begin
            radd_r <= radd;
        end
        // Read before write when both ports hit one address.
        rdata_r <= mem[radd_r];
    end

    assign wout = rdata_r;

endmodule

//--- hw/detect_pkg.sv
// Types used by the threshold detector and its checker.
package detect_pkg;

    // Hysteresis state of the level detector.
    // Entry and exit use separate thresholds.
    // The detect output is high while the state is det_active.
    typedef enum logic {
        det_idle   = 1'b0,  // Waiting for avg to reach thresh_on.
        det_active = 1'b1   // Waiting for avg to drop below thresh_off.
    } det_state_e;

endpackage

//--- hw/dsp_pkg.sv
// Types used by the signal processing stages of the envelope detector.
package dsp_pkg;

    // Output scaling of the moving average.
    // The sum is divided by a power-of-two window length.
    // So only the low log2(window) bits of the sum form the fraction.
    typedef enum logic [1:0] {
        approx_truncate = 2'd0,  // Fraction is dropped.
        approx_nearest  = 2'd1   // Fraction of one half or more rounds up.
    } approx_e;

endpackage
